//--- run_sim.sh
#!/usr/bin/env bash
# Build the peripheral testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f --top-module tb_periph -o sim_periph

sim_out=$(./obj_dir/sim_periph)
echo "$sim_out"

if grep -qx "Testbench passed" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

//--- src/periph_fifo.sv
/* Synchronous FIFO, first word fall-through, with occupancy count
   and flush; payload type is a parameter */
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_fifo #(
    parameter type item_t = periph_pkg::tx_byte_t
) (
    input  wire logic clk,
    input  wire logic rstz,
    txq_if.fifo       q
);

    localparam int DEPTH = `PERIPH_TXQ_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam periph_pkg::txq_level_t FULL_LVL = periph_pkg::txq_level_t'(DEPTH);

    item_t                   mem [DEPTH];
    logic [AW-1:0]           wptr_q;
    logic [AW-1:0]           rptr_q;
    periph_pkg::txq_level_t  count_q;
    logic                    do_push;
    logic                    do_pop;

    assign do_push = q.push & ~q.full;
    assign do_pop  = q.pop & ~q.empty;

    // ----------------------------------------------------------
    // Pointers and level
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else if (q.clear) begin
            wptr_q  <= '0;       // Flush wins over push and pop
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push)
                wptr_q <= wptr_q + 1'b1;     // Wraps, depth is a power of two
            if (do_pop)
                rptr_q <= rptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;                   // Both or neither, level holds
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wptr_q] <= q.wdata;
    end

    assign q.rdata = mem[rptr_q];    // Head shown before the pop
    assign q.level = count_q;
    assign q.full  = (count_q == FULL_LVL);
    assign q.empty = (count_q == '0);

    a_level_bound: assert property (@(posedge clk) disable iff (!rstz)
        count_q <= FULL_LVL);

endmodule

`default_nettype wire

//--- src/periph_gpreg.sv
/* General purpose register block, Wishbone classic slave with
   registered feedback; scratch, boot vector, GPIO and UART control */
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_gpreg (
    input  wire logic               clk,
    input  wire logic               rstz,
    input  wire logic [5:0]         adr_i,
    input  wire logic [31:0]        dat_i,
    input  wire logic               we_i,
    input  wire logic               stb_i,
    output logic [31:0]             dat_o,
    output logic                    ack_o,
    output logic [15:0]             gpio_dir_o,
    output logic [15:0]             gpio_write_o,
    input  wire logic [15:0]        gpio_read_i,
    output periph_pkg::presc_t      uart_presc_o,
    txq_if.ctrl                     txq
);

    localparam int LVL_PAD = 32 - $bits(periph_pkg::txq_level_t);

    logic        ack_q;
    logic        clear_q;     // tx clear one-shot
    logic [31:0] scratch_q;
    logic [23:0] bootvec_q;
    logic        access;

    assign access = stb_i & ~ack_q;   // First cycle of a strobe only

    // ----------------------------------------------------------
    // Register writes
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            scratch_q    <= '0;
            bootvec_q    <= `PERIPH_BOOTVEC_RST;
            gpio_dir_o   <= '0;          // All inputs
            gpio_write_o <= '0;
            uart_presc_o <= `PERIPH_UART_PRESC_RST;
            clear_q      <= 1'b0;
        end else if (access && we_i) begin
            case (adr_i)
                `PERIPH_ADR_SCRATCH:    scratch_q    <= dat_i;
                `PERIPH_ADR_BOOTVEC:    bootvec_q    <= dat_i[23:0];
                `PERIPH_ADR_GPIO_DIR:   gpio_dir_o   <= dat_i[15:0];
                `PERIPH_ADR_GPIO_WRITE: gpio_write_o <= dat_i[15:0];
                `PERIPH_ADR_UART_CTRL: begin
                    uart_presc_o <= dat_i[11:0];
                    clear_q      <= dat_i[12];
                end
                default: ;                   // Read only or unmapped
            endcase
        end else if (ack_q) begin
            clear_q <= 1'b0;                 // Drop the one-shot with ack
        end
    end

    // ----------------------------------------------------------
    // Read data, captured along with the ack
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (access && !we_i) begin
            case (adr_i)
                `PERIPH_ADR_SCRATCH:     dat_o <= scratch_q;
                `PERIPH_ADR_BOOTVEC:     dat_o <= {8'h0, bootvec_q};
                `PERIPH_ADR_GPIO_DIR:    dat_o <= {16'h0, gpio_dir_o};
                `PERIPH_ADR_GPIO_WRITE:  dat_o <= {16'h0, gpio_write_o};
                `PERIPH_ADR_GPIO_READ:   dat_o <= {16'h0, gpio_read_i};
                `PERIPH_ADR_UART_CTRL:   dat_o <= {20'h0, uart_presc_o};
                `PERIPH_ADR_UART_STATUS: dat_o <= {{LVL_PAD{1'b0}}, txq.level};
                default:                 dat_o <= '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign ack_o     = ack_q;
    assign txq.clear = clear_q;

    // Classic registered feedback, one ack per strobe
    a_ack_single: assert property (@(posedge clk) disable iff (!rstz)
        ack_q |=> !ack_q);

endmodule

`default_nettype wire

//--- src/periph_params.svh
/* Register word addresses, transmit FIFO depth and reset defaults
   for the peripheral subsystem */
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// ----------------------------------------------------------
// Wishbone word addresses
// ----------------------------------------------------------
`define PERIPH_ADR_SCRATCH      6'd0
`define PERIPH_ADR_BOOTVEC      6'd1
`define PERIPH_ADR_GPIO_DIR     6'd2
`define PERIPH_ADR_GPIO_WRITE   6'd3
`define PERIPH_ADR_GPIO_READ    6'd4    // Read only
`define PERIPH_ADR_UART_CTRL    6'd5    // Prescaler, bit 12 is tx clear
`define PERIPH_ADR_UART_STATUS  6'd6    // Read only, FIFO level
`define PERIPH_ADR_UART_DATA    6'd7    // Write only, goes to the FIFO

// ----------------------------------------------------------
// Sizes and reset values
// ----------------------------------------------------------
`define PERIPH_TXQ_DEPTH        8       // Must stay a power of two
`define PERIPH_BOOTVEC_RST      24'h100000
`define PERIPH_UART_PRESC_RST   12'd207 // 115200 baud from 24 MHz

`endif

//--- src/periph_pkg.sv
/* Shared data types of the peripheral subsystem */
`default_nettype none

`include "periph_params.svh"

package periph_pkg;

    // One UART character
    typedef logic [7:0] tx_byte_t;

    // FIFO occupancy, needs one bit more than the pointers
    // so that a full FIFO of DEPTH entries can be counted
    typedef logic [$clog2(`PERIPH_TXQ_DEPTH):0] txq_level_t;

    // Baud prescaler, bit time is value plus one clocks
    typedef logic [11:0] presc_t;

endpackage

`default_nettype wire

//--- src/periph_top.sv
/* Peripheral subsystem top, Wishbone decode between register block
   and UART data port, transmit FIFO and UART */
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_top (
    input  wire logic        clk,
    input  wire logic        rstz,
    input  wire logic [5:0]  adr_i,
    input  wire logic [31:0] dat_i,
    output logic [31:0]      dat_o,
    input  wire logic        we_i,
    input  wire logic        stb_i,
    output logic             ack_o,
    output logic [15:0]      gpio_dir_o,
    output logic [15:0]      gpio_write_o,
    input  wire logic [15:0] gpio_read_i,
    output logic             uart_tx_o
);

    logic                sel_data;
    logic                sel_data_q;   // Slave of the access in flight
    logic                gp_ack;
    logic                td_ack;
    logic [31:0]         gp_dat;
    periph_pkg::presc_t  presc;

    txq_if txq ();

    // ----------------------------------------------------------
    // Address decode and return mux
    // ----------------------------------------------------------
    assign sel_data = (adr_i == `PERIPH_ADR_UART_DATA);

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz)
            sel_data_q <= 1'b0;
        else if (stb_i)
            sel_data_q <= sel_data;
    end

    assign ack_o = gp_ack | td_ack;
    assign dat_o = sel_data_q ? 32'h0 : gp_dat;   // Data port reads as zero

    periph_gpreg i_gpreg (
        .clk          (clk),
        .rstz         (rstz),
        .adr_i        (adr_i),
        .dat_i        (dat_i),
        .we_i         (we_i),
        .stb_i        (stb_i & ~sel_data),
        .dat_o        (gp_dat),
        .ack_o        (gp_ack),
        .gpio_dir_o   (gpio_dir_o),
        .gpio_write_o (gpio_write_o),
        .gpio_read_i  (gpio_read_i),
        .uart_presc_o (presc),
        .txq          (txq.ctrl)
    );

    periph_txdata i_txdata (
        .clk   (clk),
        .rstz  (rstz),
        .stb_i (stb_i & sel_data),
        .we_i  (we_i),
        .dat_i (dat_i),
        .ack_o (td_ack),
        .txq   (txq.prod)
    );

    periph_fifo #(.item_t(periph_pkg::tx_byte_t)) i_fifo (
        .clk  (clk),
        .rstz (rstz),
        .q    (txq.fifo)
    );

    periph_uart_tx i_uart_tx (
        .clk     (clk),
        .rstz    (rstz),
        .presc_i (presc),
        .txq     (txq.cons),
        .tx_o    (uart_tx_o)
    );

endmodule

`default_nettype wire

//--- src/periph_txdata.sv
/* UART data port, Wishbone slave that pushes written bytes into
   the transmit FIFO and holds the ack while the FIFO is full */
`timescale 1ns/1ps
`default_nettype none

module periph_txdata (
    input  wire logic        clk,
    input  wire logic        rstz,
    input  wire logic        stb_i,
    input  wire logic        we_i,
    input  wire logic [31:0] dat_i,
    output logic             ack_o,
    txq_if.prod              txq
);

    logic wr_pend_q;   // Write accepted, waiting for room
    logic rd_ack_q;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            wr_pend_q <= 1'b0;
            rd_ack_q  <= 1'b0;
        end else begin
            if (!wr_pend_q && !rd_ack_q)
                wr_pend_q <= stb_i & we_i;
            else if (wr_pend_q && !txq.full)
                wr_pend_q <= 1'b0;           // Pushed this cycle
            rd_ack_q <= stb_i & ~we_i & ~rd_ack_q & ~wr_pend_q;
        end
    end

    // Push and ack share the first cycle with room
    assign txq.push  = wr_pend_q & ~txq.full;
    assign txq.wdata = dat_i[7:0];           // Master holds data until ack
    assign ack_o     = txq.push | rd_ack_q;

    // Full comes from the FIFO counter, never overrun it
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstz)
        txq.push |-> !txq.full);

endmodule

`default_nettype wire

//--- src/periph_uart_tx.sv
/* UART transmitter, 8N1 frames from the transmit FIFO,
   bit time of prescaler plus one clocks */
`timescale 1ns/1ps
`default_nettype none

module periph_uart_tx (
    input  wire logic               clk,
    input  wire logic               rstz,
    input  wire periph_pkg::presc_t presc_i,
    txq_if.cons                     txq,
    output logic                    tx_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t                 state_q;
    periph_pkg::presc_t     cnt_q;      // Clocks left in this bit
    logic [2:0]             idx_q;
    periph_pkg::tx_byte_t   shreg_q;
    logic                   bit_end;
    logic                   load;

    assign bit_end = (cnt_q == '0);

    // Take a byte when idle, or straight after a stop bit
    assign load    = ~txq.empty &
                     ((state_q == ST_IDLE) | ((state_q == ST_STOP) & bit_end));
    assign txq.pop = load;

    // ----------------------------------------------------------
    // Frame FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            idx_q   <= '0;
        end else if (load) begin
            state_q <= ST_START;
            cnt_q   <= presc_i;
        end else if (state_q != ST_IDLE) begin
            if (!bit_end) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= presc_i;
                case (state_q)
                    ST_START: begin
                        state_q <= ST_DATA;
                        idx_q   <= '0;
                    end
                    ST_DATA: begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == 3'd7)
                            state_q <= ST_STOP;
                    end
                    default: state_q <= ST_IDLE;  // Stop bit done, queue empty
                endcase
            end
        end
    end

    // Shift register, LSB goes out first
    always_ff @(posedge clk) begin
        if (load)
            shreg_q <= txq.rdata;
        else if (state_q == ST_DATA && bit_end)
            shreg_q <= shreg_q >> 1;
    end

    always_comb begin
        case (state_q)
            ST_START: tx_o = 1'b0;
            ST_DATA:  tx_o = shreg_q[0];
            default:  tx_o = 1'b1;      // Idle and stop are mark
        endcase
    end

endmodule

`default_nettype wire

//--- src/txq_if.sv
/* Transmit queue interface between data port, FIFO, UART and registers */
`timescale 1ns/1ps
`default_nettype none

interface txq_if;

    logic                    push;
    periph_pkg::tx_byte_t    wdata;
    logic                    full;
    logic                    pop;
    periph_pkg::tx_byte_t    rdata;   // Head entry, valid while not empty
    logic                    empty;
    logic                    clear;
    periph_pkg::txq_level_t  level;

    // Producer side, Wishbone data port
    modport prod (output push, wdata, input full);

    // The buffer itself
    modport fifo (
        input  push, wdata, pop, clear,
        output full, rdata, empty, level
    );

    // Consumer side, UART transmitter
    modport cons (output pop, input rdata, empty);

    // Register block, flush and status
    modport ctrl (output clear, input level);

endinterface

`default_nettype wire

//--- verification/tb_periph.sv
/* Testbench for the peripheral subsystem: Wishbone master tasks, LCG,
   UART line decoder, register reference model and byte compare */
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module tb_periph;

    localparam int DEPTH   = `PERIPH_TXQ_DEPTH;
    localparam int WB_WAIT = 1000;          // Longest ack wait, covers a full FIFO
    localparam int N_REG   = 20;
    localparam int N_RAND  = 16;            // Ordering test at prescaler 3
    localparam int N_PRESS = DEPTH + 4;     // Back-pressure test at prescaler 15
    localparam int N_FILL  = DEPTH + 1;     // Clear test at prescaler 15
    localparam int CYCLE_LIMIT = N_RAND * 10 * 4 + (N_PRESS + N_FILL) * 10 * 16 + 2000;

    logic        clk;
    logic        rstz;
    logic [5:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        we;
    logic        stb;
    logic        ack;
    logic [15:0] gpio_dir;
    logic [15:0] gpio_write;
    logic [15:0] gpio_read;
    logic        uart_tx;

    logic [31:0] rand_state = 32'hcf19_1e82;
    logic [31:0] shadow [64];               // Last written value per address
    logic [7:0]  exp_q [$];
    logic [7:0]  rx_q [$];
    int          cur_presc = 207;
    int          frames_started = 0;
    int          err_value = 0;
    int          err_other = 0;
    int          cycles = 0;

    periph_top i_periph_top (
        .clk          (clk),
        .rstz         (rstz),
        .adr_i        (adr),
        .dat_i        (dat_w),
        .dat_o        (dat_r),
        .we_i         (we),
        .stb_i        (stb),
        .ack_o        (ack),
        .gpio_dir_o   (gpio_dir),
        .gpio_write_o (gpio_write),
        .gpio_read_i  (gpio_read),
        .uart_tx_o    (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [31:0] reg_expect(input logic [5:0] a, input logic [31:0] s [64]);
        case (a)
            `PERIPH_ADR_SCRATCH:     return s[a];
            `PERIPH_ADR_BOOTVEC:     return {8'h0, s[a][23:0]};
            `PERIPH_ADR_GPIO_DIR,
            `PERIPH_ADR_GPIO_WRITE,
            `PERIPH_ADR_GPIO_READ:   return {16'h0, s[a][15:0]};
            `PERIPH_ADR_UART_CTRL:   return {20'h0, s[a][11:0]};  // Clear bit reads as 0
            `PERIPH_ADR_UART_STATUS: return {28'h0, s[a][3:0]};
            default:                 return 32'h0;                // Data port reads zero
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // One classic cycle, entered 1 ns after a rising edge
    task automatic run_access(input logic [5:0] a, input logic [31:0] d, input logic w,
                              output logic [31:0] rd);
        int waited;
        waited = 0;
        adr = a;
        dat_w = d;
        we = w;
        stb = 1'b1;
        @(negedge clk);
        while (!ack && waited < WB_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (ack) else begin
            err_other++;
            $display("No ack within %0d cycles at address %0h", WB_WAIT, a);
        end
        rd = dat_r;                         // Valid while ack is high
        wait_cycles(1);
        stb = 1'b0;
        we = 1'b0;
        @(negedge clk);
        assert (!ack) else begin
            err_other++;
            $display("Ack stayed high for a second cycle at address %0h", a);
        end
        wait_cycles(1);
    endtask

    task automatic wb_write(input logic [5:0] a, input logic [31:0] d);
        logic [31:0] unused_rd;
        run_access(a, d, 1'b1, unused_rd);
    endtask

    task automatic wb_read(input logic [5:0] a, output logic [31:0] d);
        run_access(a, 32'h0, 1'b0, d);
    endtask

    task automatic check_read(input logic [5:0] a);
        logic [31:0] got;
        logic [31:0] exp;
        wb_read(a, got);
        exp = reg_expect(a, shadow);
        assert (got == exp) else begin
            err_value++;
            $display("[FAIL] dat_o at address %0h: expected %08h, got %08h", a, exp, got);
        end
    endtask

    task automatic send_byte(input logic [31:0] d);
        wb_write(`PERIPH_ADR_UART_DATA, d);
        exp_q.push_back(d[7:0]);            // Upper bits are ignored by the port
    endtask

    // ------------------------------------------------------------
    // UART line decoder, samples at bit centers
    // ------------------------------------------------------------
    initial begin : uart_monitor
        logic [7:0] shift;
        logic       prev;
        int         bit_cycles;
        prev = 1'b1;
        shift = '0;
        forever begin
            @(negedge clk);
            if (rstz && prev && !uart_tx) begin
                frames_started++;
                bit_cycles = cur_presc + 1;
                repeat (bit_cycles / 2) @(negedge clk);
                assert (uart_tx == 1'b0) else begin
                    err_value++;
                    $display("[FAIL] uart_tx_o start bit: expected 0, got %0h", uart_tx);
                end
                repeat (8) begin
                    repeat (bit_cycles) @(negedge clk);
                    shift = {uart_tx, shift[7:1]};   // LSB arrives first
                end
                repeat (bit_cycles) @(negedge clk);
                assert (uart_tx == 1'b1) else begin
                    err_value++;
                    $display("[FAIL] uart_tx_o stop bit: expected 1, got %0h", uart_tx);
                end
                rx_q.push_back(shift);
            end
            prev = uart_tx;
        end
    end

    initial begin : compare_bytes
        logic [7:0] got;
        logic [7:0] exp;
        forever begin
            @(negedge clk);
            if (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                if (exp_q.size() == 0) begin
                    err_other++;
                    $display("Byte %02h came out of the UART but none was expected", got);
                end else begin
                    exp = exp_q.pop_front();
                    assert (got == exp) else begin
                        err_value++;
                        $display("[FAIL] uart_tx_o byte: expected %02h, got %02h", exp, got);
                    end
                end
            end
        end
    end

    initial begin : cycle_limit
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped at the %0d cycle limit before the tests ended", CYCLE_LIMIT);
        $display("Errors: %0d value, %0d other", err_value, err_other);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin : main
        logic [31:0] r;
        logic [31:0] rd;
        logic [7:0]  drop;
        logic [5:0]  a;
        int          base;
        rstz = 1'b0;
        adr = '0;
        dat_w = '0;
        we = 1'b0;
        stb = 1'b0;
        r = next_rand();
        gpio_read = r[15:0];
        foreach (shadow[i]) shadow[i] = 32'h0;
        shadow[`PERIPH_ADR_BOOTVEC]   = {8'h0, `PERIPH_BOOTVEC_RST};
        shadow[`PERIPH_ADR_UART_CTRL] = {20'h0, `PERIPH_UART_PRESC_RST};
        shadow[`PERIPH_ADR_GPIO_READ] = {16'h0, r[15:0]};
        wait_cycles(10);
        rstz = 1'b1;
        wait_cycles(2);

        // Reset values
        for (int i = 0; i < 8; i++) check_read(6'(i));
        assert (uart_tx == 1'b1) else begin
            err_value++;
            $display("[FAIL] uart_tx_o after reset: expected 1, got %0h", uart_tx);
        end

        // Random register traffic
        for (int k = 0; k < N_REG; k++) begin
            case (k % 5)
                0:       a = `PERIPH_ADR_SCRATCH;
                1:       a = `PERIPH_ADR_BOOTVEC;
                2:       a = `PERIPH_ADR_GPIO_DIR;
                3:       a = `PERIPH_ADR_GPIO_WRITE;
                default: a = `PERIPH_ADR_UART_CTRL;
            endcase
            r = next_rand();
            wb_write(a, r);
            shadow[a] = r;
            r = next_rand();
            gpio_read = r[15:0];
            shadow[`PERIPH_ADR_GPIO_READ] = {16'h0, r[15:0]};
            check_read(a);
            check_read(`PERIPH_ADR_GPIO_READ);
            assert (gpio_dir == shadow[`PERIPH_ADR_GPIO_DIR][15:0] &&
                    gpio_write == shadow[`PERIPH_ADR_GPIO_WRITE][15:0]) else begin
                err_value++;
                $display("[FAIL] gpio_dir_o/gpio_write_o: expected %04h/%04h, got %04h/%04h",
                         shadow[`PERIPH_ADR_GPIO_DIR][15:0],
                         shadow[`PERIPH_ADR_GPIO_WRITE][15:0], gpio_dir, gpio_write);
            end
        end

        // Byte order at prescaler 3
        wb_write(`PERIPH_ADR_UART_CTRL, 32'd3);
        cur_presc = 3;
        for (int k = 0; k < N_RAND; k++) send_byte(next_rand());
        while (exp_q.size() != 0) wait_cycles(1);
        wait_cycles(2 * (cur_presc + 1));

        // Back-pressure at prescaler 15
        wb_write(`PERIPH_ADR_UART_CTRL, 32'd15);
        cur_presc = 15;
        for (int k = 0; k < N_PRESS; k++) send_byte(next_rand());
        while (exp_q.size() != 0) begin
            wb_read(`PERIPH_ADR_UART_STATUS, rd);
            assert (rd <= DEPTH) else begin
                err_value++;
                $display("[FAIL] dat_o UART_STATUS: expected at most %0h, got %08h", DEPTH, rd);
            end
            wait_cycles(20);
        end
        wait_cycles(2 * (cur_presc + 1));

        // Clear while the first frame is on the line
        base = frames_started;
        for (int k = 0; k < N_FILL; k++) send_byte(next_rand());
        while (frames_started == base) wait_cycles(1);
        r = 32'h0000_1000 | 32'd15;
        wb_write(`PERIPH_ADR_UART_CTRL, r);
        shadow[`PERIPH_ADR_UART_CTRL] = r;
        check_read(`PERIPH_ADR_UART_STATUS);
        while (exp_q.size() > 1) drop = exp_q.pop_back();  // Flushed with the FIFO
        wait_cycles(20 * (cur_presc + 1));
        assert (frames_started == base + 1 && exp_q.size() == 0 && rx_q.size() == 0)
        else begin
            err_other++;
            $display("After the clear %0d frames were sent where only one was expected",
                     frames_started - base);
        end

        $display("Errors: %0d value, %0d other", err_value, err_other);
        if (err_value == 0 && err_other == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/periph_pkg.sv
src/txq_if.sv
src/periph_gpreg.sv
src/periph_txdata.sv
src/periph_fifo.sv
src/periph_uart_tx.sv
src/periph_top.sv
verification/tb_periph.sv
